//--- filelist.f
+incdir+test
source/gf13_pkg.sv
source/bch_pkg.sv
source/gf13_mult.sv
source/bchecc_syndm_lane.sv
source/bchecc_syndm.sv
test/tb_bchecc_syndm.sv

//--- Bender.yml
package:
  name: bchecc_syndm

sources:
  # packages first, field before code
  - source/gf13_pkg.sv
  - source/bch_pkg.sv
  # datapath, leaf modules before the top
  - source/gf13_mult.sv
  - source/bchecc_syndm_lane.sv
  - source/bchecc_syndm.sv
  # testbench, includes the reference model header
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_bchecc_syndm.sv

//--- test/bch_ref_model.svh
`ifndef BCH_REF_MODEL_SVH
`define BCH_REF_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bit-serial syndrome model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam logic [12:0] REF_POLY = 13'h001B;    // x^13 = x^4 + x^3 + x + 1.

gf_elem_t ref_s [NUM_SYNDM];                    // S1, S3 .. S29.
int       ref_lanes;                            // lanes that advance.

function automatic gf_elem_t ref_times_alpha(input gf_elem_t x);
    gf_elem_t y;
    y = x << 1;
    if (x[GF_W-1])
    begin
        y = y ^ REF_POLY;                       // fold the x^13 term.
    end
    return y;
endfunction

function automatic gf_elem_t ref_alpha_pow(input int n);
    gf_elem_t acc;
    acc = gf_elem_t'(1);
    for (int k = 0; k < n; k++)
    begin
        acc = ref_times_alpha(acc);
    end
    return acc;
endfunction

// one Horner step, S * alpha^idx + bit.
function automatic gf_elem_t ref_horner_bit(input gf_elem_t s, input int idx, input logic b);
    gf_elem_t acc;
    acc = s;
    for (int k = 0; k < idx; k++)
    begin
        acc = ref_times_alpha(acc);
    end
    acc[0] = acc[0] ^ b;
    return acc;
endfunction

task automatic ref_clear();
    for (int j = 0; j < NUM_SYNDM; j++)
    begin
        ref_s[j] = '0;
    end
endtask

// bit 0 of the byte is taken first.
task automatic ref_push_byte(input logic [DATA_W-1:0] d);
    for (int j = 0; j < ref_lanes; j++)
    begin
        for (int k = 0; k < DATA_W; k++)
        begin
            ref_s[j] = ref_horner_bit(ref_s[j], 2 * j + 1, d[k]);
        end
    end
endtask

`endif

//--- test/tb_bchecc_syndm.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bchecc_syndm
    import gf13_pkg::*;
    import bch_pkg::*;
();

    localparam int STREAM_BYTES = 64;
    localparam int T8_BYTES = 32;
    localparam int SHORT_BYTES = 8;
    localparam int CW_BYTES = 40;
    localparam int MAX_CYCLES = 2000;   // watchdog limit.

    logic        clk;
    logic        rst_n;
    logic        init;
    dec_byte_t   dec;
    ecc_mode_e   mode;
    syndm_set_t  syndm;
    logic [15:0] lfsr_state;
    int          err_count;
    int          check_count;

    `include "bch_ref_model.svh"

    bchecc_syndm u_bchecc_syndm
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .init_i  (init),
        .dec_i   (dec),
        .mode_i  (mode),
        .syndm_o (syndm)
    );

    always #4 clk = ~clk;               // 8 ns period.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [DATA_W-1:0] b);
        for (int k = 0; k < DATA_W; k++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            b[k] = lfsr_state[0];
        end
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        for (int n = 0; n < 3; n++)
        begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
    endtask

    // init pulse, mode fixed for the codeword.
    task automatic start_codeword(input ecc_mode_e m);
        @(posedge clk);
        init <= 1'b1;
        mode <= m;
        dec.avail <= 1'b0;
        @(posedge clk);
        init <= 1'b0;
        ref_clear();
        ref_lanes = (m == ECC_T15) ? NUM_SYNDM : SHORT_SYNDM;
    endtask

    task automatic send_byte(input logic [DATA_W-1:0] b);
        @(posedge clk);
        dec.avail <= 1'b1;
        dec.data <= b;
        ref_push_byte(b);
    endtask

    // last byte lands on this edge.
    task automatic finish_stream();
        @(posedge clk);
        dec.avail <= 1'b0;
        @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_lane(input string name, input int j, input gf_elem_t exp);
        check_count++;
        assert (syndm[j] === exp)
        else
        begin
            $display("Fail %s: S%0d expected %h actual %h", name, 2 * j + 1, exp, syndm[j]);
            err_count++;
        end
    endtask

    task automatic check_all(input string name);
        for (int j = 0; j < NUM_SYNDM; j++)
        begin
            check_lane(name, j, ref_s[j]);
        end
    endtask

    task automatic check_zero(input string name);
        for (int j = 0; j < NUM_SYNDM; j++)
        begin
            check_lane(name, j, '0);
        end
    endtask

    // bus noise while avail is low.
    task automatic idle_cycles(input string name, input int count);
        for (int n = 0; n < count; n++)
        begin
            @(posedge clk);
            dec.avail <= 1'b0;
            dec.data <= ~dec.data;
            @(negedge clk);
            check_all(name);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset_zero();
        @(negedge clk);
        check_zero("reset_zero");
    endtask

    task automatic test_single_byte();
        start_codeword(ECC_T15);
        send_byte(8'h80);
        finish_stream();
        for (int j = 0; j < NUM_SYNDM; j++)
        begin
            check_lane("single_byte_80", j, gf_elem_t'(1));
        end
        start_codeword(ECC_T15);
        send_byte(8'h01);
        finish_stream();
        for (int j = 0; j < NUM_SYNDM; j++)
        begin
            check_lane("single_byte_01", j, ref_alpha_pow(7 * (2 * j + 1)));
        end
    endtask

    task automatic test_stream_t15();
        logic [DATA_W-1:0] b;
        start_codeword(ECC_T15);
        for (int n = 0; n < STREAM_BYTES; n++)
        begin
            rand_byte(b);
            send_byte(b);
            if (n % 7 == 3)
            begin
                idle_cycles("stream_t15_idle", 1 + n % 2);
            end
        end
        finish_stream();
        check_all("stream_t15");
    endtask

    // upper lanes must hold what init left them.
    task automatic test_t8_mode();
        logic [DATA_W-1:0] b;
        start_codeword(ECC_T8);
        for (int n = 0; n < T8_BYTES; n++)
        begin
            rand_byte(b);
            send_byte(b);
        end
        finish_stream();
        check_all("t8_mode");
    endtask

    task automatic test_init_clear();
        logic [DATA_W-1:0] b;
        start_codeword(ECC_T15);
        for (int n = 0; n < SHORT_BYTES; n++)
        begin
            rand_byte(b);
            send_byte(b);
        end
        finish_stream();
        check_all("init_clear_pre");
        start_codeword(ECC_T15);
        @(negedge clk);
        check_zero("init_clear");
        rand_byte(b);
        @(posedge clk);
        init <= 1'b1;
        dec.avail <= 1'b1;
        dec.data <= b;
        @(posedge clk);
        init <= 1'b0;
        dec.avail <= 1'b0;
        @(negedge clk);
        check_zero("init_with_strobe");
    endtask

    task automatic test_two_codewords();
        logic [DATA_W-1:0] b;
        for (int w = 0; w < 2; w++)
        begin
            start_codeword(ECC_T15);
            for (int n = 0; n < CW_BYTES; n++)
            begin
                rand_byte(b);
                send_byte(b);
            end
            finish_stream();
            check_all("two_codewords");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // run control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        for (int n = 0; n < MAX_CYCLES; n++)
        begin
            @(posedge clk);
        end
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        init = 1'b0;
        dec = '0;
        mode = ECC_T15;
        lfsr_state = 16'd71;
        err_count = 0;
        check_count = 0;
        ref_lanes = NUM_SYNDM;
        ref_clear();
        apply_reset();
        test_reset_zero();
        test_single_byte();
        test_stream_t15();
        test_t8_mode();
        test_init_clear();
        test_two_codewords();
        $display("checks %0d errors %0d", check_count, err_count);
        if (err_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/bchecc_syndm.sv
`timescale 1ns/1ps
`default_nettype none

module bchecc_syndm
    import bch_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       init_i,
    input  wire dec_byte_t  dec_i,
    input  wire ecc_mode_e  mode_i,
    output wire syndm_set_t syndm_o
);

    logic                 long_en;      // upper lanes run.
    logic [NUM_SYNDM-1:0] lane_load;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane enables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign long_en = (mode_i == ECC_T15);

    // In t=8 mode the upper lanes freeze rather than clear, so their
    // contents stay visible until the next init.
    always_comb
    begin
        for (int j = 0; j < NUM_SYNDM; j++)
        begin
            if (j < SHORT_SYNDM)
            begin
                lane_load[j] = dec_i.avail;
            end
            else
            begin
                lane_load[j] = dec_i.avail & long_en;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // syndrome lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar j = 0; j < NUM_SYNDM; j++)
    begin : g_lane
        bchecc_syndm_lane #(
            .SYNDM_IDX (syndm_idx(j))   // S1, S3, ... S29.
        ) u_bchecc_syndm_lane
        (
            .clk     (clk),
            .rst_n   (rst_n),
            .clear_i (init_i),
            .load_i  (lane_load[j]),
            .data_i  (dec_i.data),
            .syndm_o (syndm_o[j])
        );
    end

endmodule

`default_nettype wire

//--- source/bchecc_syndm_lane.sv
`timescale 1ns/1ps
`default_nettype none

module bchecc_syndm_lane
    import gf13_pkg::*;
    import bch_pkg::*;
#(
    parameter int SYNDM_IDX = 1     // odd syndrome index i.
)
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              clear_i,
    input  wire logic              load_i,
    input  wire logic [DATA_W-1:0] data_i,
    output gf_elem_t               syndm_o
);

    // one byte shifts the running value by eight bit positions.
    localparam gf_elem_t FB_CONST = gf_alpha_pow(8 * SYNDM_IDX);

    gf_elem_t              syndm_q;
    gf_elem_t              fb_prod;
    gf_elem_t              byte_term;
    gf_elem_t              syndm_nxt;
    gf_elem_t [DATA_W-1:0] bit_term;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // feedback multiply
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    gf13_mult u_gf13_mult
    (
        .a_i (syndm_q),
        .b_i (FB_CONST),
        .p_o (fb_prod)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte contribution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bit 0 arrives first, so it picks up the highest power.
    for (genvar m = 0; m < DATA_W; m++)
    begin : g_bit
        localparam gf_elem_t BIT_CONST = gf_alpha_pow(SYNDM_IDX * m);

        assign bit_term[m] = data_i[DATA_W-1-m] ? BIT_CONST : '0;
    end

    always_comb
    begin
        byte_term = '0;
        for (int m = 0; m < DATA_W; m++)
        begin
            byte_term = byte_term ^ bit_term[m];
        end
    end

    assign syndm_nxt = fb_prod ^ byte_term;     // horner step, eight bits wide.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // syndrome register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            syndm_q <= '0;
        end
        else if (clear_i)
        begin
            syndm_q <= '0;                      // clear beats load.
        end
        else if (load_i)
        begin
            syndm_q <= syndm_nxt;
        end
    end

    assign syndm_o = syndm_q;

endmodule

`default_nettype wire

//--- source/gf13_mult.sv
`timescale 1ns/1ps
`default_nettype none

module gf13_mult
    import gf13_pkg::*;
(
    input  wire gf_elem_t a_i,
    input  wire gf_elem_t b_i,
    output gf_elem_t      p_o
);

    logic [GF_PROD_W-1:0] clmul;    // unreduced product, degree <= 24.
    logic [GF_PROD_W-1:0] red;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // carry-less product
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        clmul = '0;
        for (int k = 0; k < GF_W; k++)
        begin
            if (b_i[k])
            begin
                clmul = clmul ^ (GF_PROD_W'(a_i) << k);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // modular reduction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Work from the top term down. Each set bit k >= 13 is cancelled by
    // x^(k-13) times the full field polynomial, which only touches lower bits.
    always_comb
    begin
        red = clmul;
        for (int k = GF_PROD_W - 1; k >= GF_W; k--)
        begin
            if (red[k])
            begin
                red = red ^ (GF_PROD_W'({1'b1, GF_POLY}) << (k - GF_W)); // clears bit k.
            end
        end
    end

    assign p_o = red[GF_W-1:0];

endmodule

`default_nettype wire

//--- source/bch_pkg.sv
`default_nettype none

package bch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // code parameters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DATA_W = 8;          // one byte per strobe.
    localparam int NUM_SYNDM = 15;      // S1 .. S29, odd only.
    localparam int SHORT_SYNDM = 8;     // S1 .. S15 in t=8 mode.

    // ecc_mode_e picks the correction strength
    typedef enum logic
    {
        ECC_T8  = 1'b0,
        ECC_T15 = 1'b1
    } ecc_mode_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed
    {
        logic              avail;       // byte strobe.
        logic [DATA_W-1:0] data;
    } dec_byte_t;

    // element j carries S(2j+1).
    typedef gf13_pkg::gf_elem_t [NUM_SYNDM-1:0] syndm_set_t;

    // odd syndrome index served by lane j.
    function automatic int syndm_idx(input int lane);
        return 2 * lane + 1;
    endfunction

endpackage

`default_nettype wire

//--- source/gf13_pkg.sv
`default_nettype none

package gf13_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field definition
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int GF_W = 13;                           // bits per element.
    localparam int GF_PROD_W = 2 * GF_W - 1;            // raw carry-less product.
    localparam int unsigned GF_ORDER = (1 << GF_W) - 1; // multiplicative group size.

    localparam logic [GF_W-1:0] GF_POLY = 13'h001B;     // x^4 + x^3 + x + 1.
    localparam logic [GF_W-1:0] GF_ALPHA = 13'h0002;    // primitive element x.

    typedef logic [GF_W-1:0] gf_elem_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // elaboration helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // shift and add, one bit of b at a time.
    function automatic gf_elem_t gf_mul_const(input gf_elem_t a, input gf_elem_t b);
        gf_elem_t acc;
        gf_elem_t sh;
        acc = '0;
        sh = a;
        for (int k = 0; k < GF_W; k++)
        begin
            if (b[k])
            begin
                acc = acc ^ sh;
            end
            sh = sh[GF_W-1] ? ((sh << 1) ^ GF_POLY) : (sh << 1); // x^13 folds back.
        end
        return acc;
    endfunction

    function automatic gf_elem_t gf_alpha_pow(input int unsigned n);
        gf_elem_t acc;
        int unsigned e;
        acc = gf_elem_t'(1);
        e = n % GF_ORDER;                               // alpha^8191 = 1.
        for (int unsigned k = 0; k < e; k++)
        begin
            acc = gf_mul_const(acc, GF_ALPHA);
        end
        return acc;
    endfunction

endpackage

`default_nettype wire
